// ==== common/sdrx_config.svh ====
/*
 * build-time sizes for the SD card SPI receive path
 * include wherever buffer widths, the CRC polynomial or SCK rate are needed
 */
`ifndef SDRX_CONFIG_SVH
`define SDRX_CONFIG_SVH

// buffer word and address widths, top address bit picks the region
`define SDRX_DW 32
`define SDRX_AW 8

// CRC-16 CCITT, as used on SD data blocks
`define SDRX_CRC_POLY 16'h1021

// i_clk cycles per SCK half period
`define SDRX_SCK_HALF 2

`endif

// ==== common/sdrx_pkg.sv ====
/*
 * shared types for the SD receive path
 * request, buffer write and response structs plus the token byte decode
 */
`default_nettype none

`include "sdrx_config.svh"

package sdrx_pkg;

	// data start token for single block reads
	localparam logic [7:0] SD_START_TOKEN = 8'hFE;
	// response code on CRC mismatch
	localparam logic [7:0] SD_RESP_CRC_ERR = 8'h10;

	// host read request
	typedef struct packed {
		logic [3:0] lgblksz;
		logic       buf_sel;
	} rx_req_t;

	// one buffer word write
	typedef struct packed {
		logic                 en;
		logic [`SDRX_AW-1:0] addr;
		logic [`SDRX_DW-1:0] data;
	} rx_wr_t;

	// transfer result back to the sequencer
	typedef struct packed {
		logic       valid;
		logic [7:0] code;
	} rx_resp_t;

	// data error token layout, upper nibble always zero
	typedef struct packed {
		logic [3:0] zero;
		logic       out_of_range;
		logic       card_ecc;
		logic       cc_err;
		logic       generic_err;
	} sd_err_tok_t;

	// every byte before the token is read both ways
	typedef union packed {
		logic [7:0]  raw;
		sd_err_tok_t err_tok;
	} sd_token_u;

endpackage

`default_nettype wire

// ==== design/spi_byte_rx.sv ====
/*
 * SPI mode 0 byte receiver, makes SCK from i_clk and samples MISO on rising SCK
 * one o_stb pulse per byte, MSB first, byte held on o_byte until the next one
 */
`timescale 1ns/1ps
`default_nettype none

`include "sdrx_config.svh"

module spi_byte_rx (
	input  wire        i_clk,
	input  wire        i_reset,
	input  wire        i_en,
	input  wire        i_miso,
	output logic       o_sck,
	output logic       o_stb,
	output logic [7:0] o_byte
);

	localparam logic [7:0] DIV_LAST = 8'(`SDRX_SCK_HALF - 1);

	logic [7:0] div_cnt;
	logic [2:0] bit_cnt;
	logic [7:0] shift;
	logic       running;
	logic       sck_edge;

	// keep clocking until the byte in flight is done and SCK is back low
	assign running = i_en || o_sck || (bit_cnt != 3'd0);
	// SCK toggles on this cycle
	assign sck_edge = running && (div_cnt == DIV_LAST);

	////////////////////
	// clock divider and bit count
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			div_cnt <= '0;
			o_sck <= 1'b0;
			bit_cnt <= '0;
			o_stb <= 1'b0;
		end
		else
		begin
			o_stb <= 1'b0;
			if (!running)
				div_cnt <= '0;
			else if (!sck_edge)
				div_cnt <= div_cnt + 8'd1;
			else
			begin
				div_cnt <= '0;
				o_sck <= !o_sck;
				// rising edge, one more bit in
				if (!o_sck)
				begin
					bit_cnt <= bit_cnt + 3'd1;
					o_stb <= (bit_cnt == 3'd7);
				end
			end
		end
	end

	////////////////////
	// shift register, MSB arrives first
	always_ff @(posedge i_clk)
	begin
		if (sck_edge && !o_sck)
			shift <= {shift[6:0], i_miso};
	end

	assign o_byte = shift;

endmodule

`default_nettype wire

// ==== sd_rx/sd_crc16.sv ====
/*
 * CRC-16 CCITT over a byte stream, two bits folded per clock
 * pulse i_stb with a byte, remainder settles 4 cycles later, i_clear zeroes it
 */
`timescale 1ns/1ps
`default_nettype none

`include "sdrx_config.svh"

module sd_crc16 (
	input  wire         i_clk,
	input  wire         i_clear,
	input  wire         i_stb,
	input  wire  [7:0]  i_byte,
	output logic [15:0] o_crc
);

	localparam logic [15:0] POLY = `SDRX_CRC_POLY;

	logic [7:0] sr;
	logic [1:0] phase;
	logic [1:0] bits;

	// shift two message bits into the remainder
	function automatic logic [15:0] fold2(input logic [15:0] c, input logic [1:0] d);
		logic [15:0] t;
		t = {c[14:0], 1'b0} ^ (((c[15] ^ d[1])) ? POLY : 16'h0000);
		return {t[14:0], 1'b0} ^ (((t[15] ^ d[0])) ? POLY : 16'h0000);
	endfunction

	// first pair straight from the incoming byte
	assign bits = i_stb ? i_byte[7:6] : sr[7:6];

	always_ff @(posedge i_clk)
	begin
		if (i_clear)
		begin
			o_crc <= '0;
			phase <= '0;
		end
		else if (i_stb)
		begin
			o_crc <= fold2(o_crc, bits);
			sr <= {i_byte[5:0], 2'b00};
			// three more pairs to go
			phase <= 2'd3;
		end
		else if (phase != 2'd0)
		begin
			o_crc <= fold2(o_crc, bits);
			sr <= {sr[5:0], 2'b00};
			phase <= phase - 2'd1;
		end
	end

endmodule

`default_nettype wire

// ==== sd_rx/sd_rx_data.sv ====
/*
 * block data receiver, waits for a token then packs bytes into 32-bit words
 * big-endian, checks the trailing CRC-16 and reports one response byte
 */
`timescale 1ns/1ps
`default_nettype none

`include "sdrx_config.svh"

module sd_rx_data
	import sdrx_pkg::*;
(
	input  wire         i_clk,
	input  wire         i_reset,
	input  wire         i_start,
	input  wire rx_req_t i_req,
	output logic        o_busy,
	input  wire         i_stb,
	input  wire  [7:0]  i_byte,
	output rx_wr_t      o_wr,
	output rx_resp_t    o_resp
);

	typedef enum logic [1:0] {
		ST_TOKEN,
		ST_DATA,
		ST_CRC,
		ST_DONE
	} rx_state_t;

	localparam logic [`SDRX_AW-1:0] ONE_W = 1;

	rx_state_t             state;
	sd_token_u             tok;
	logic                  is_start;
	logic                  is_error;
	logic [1:0]            fill;
	logic [23:0]           gearbox;
	logic [`SDRX_AW-2:0]  wcnt;
	logic [`SDRX_AW-1:0]  last_idx;
	logic                  last_word;
	logic                  crc_second;
	logic                  crc_hi_ok;
	logic [15:0]           crc;
	logic                  crc_clear;
	logic                  crc_stb;
	logic                  wr_en;
	logic [`SDRX_AW-1:0]  wr_addr;
	logic [`SDRX_DW-1:0]  wr_data;
	logic                  resp_valid;
	logic [7:0]            resp_code;

	////////////////////
	// token decode

	assign tok.raw = i_byte;
	assign is_start = (tok.raw == SD_START_TOKEN);
	// any byte with a clear upper nibble is a data error token
	assign is_error = (tok.err_tok.zero == 4'h0);

	// index of the last word in the block, 2^lgblksz / 4 words
	assign last_idx = (ONE_W << (i_req.lgblksz - 4'd2)) - ONE_W;
	assign last_word = ({1'b0, wcnt} == last_idx);

	// busy follows start, one cycle late
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_busy <= 1'b0;
		else
			o_busy <= i_start;
	end

	////////////////////
	// phase sequencing

	always_ff @(posedge i_clk)
	begin
		if (i_reset || !o_busy)
		begin
			state <= ST_TOKEN;
			fill <= '0;
			wcnt <= '0;
			crc_second <= 1'b0;
			wr_en <= 1'b0;
			resp_valid <= 1'b0;
		end
		else
		begin
			wr_en <= 1'b0;
			if (i_stb)
			begin
				case (state)
				ST_TOKEN:
				begin
					if (is_start)
						state <= ST_DATA;
					else if (is_error)
					begin
						resp_valid <= 1'b1;
						state <= ST_DONE;
					end
				end
				ST_DATA:
				begin
					fill <= fill + 2'd1;
					// fourth byte closes the word
					if (fill == 2'd3)
					begin
						wr_en <= 1'b1;
						wcnt <= wcnt + 1'b1;
						if (last_word)
							state <= ST_CRC;
					end
				end
				ST_CRC:
				begin
					crc_second <= 1'b1;
					if (crc_second)
					begin
						resp_valid <= 1'b1;
						state <= ST_DONE;
					end
				end
				// response held, later bytes dropped
				default:
				begin
				end
				endcase
			end
		end
	end

	////////////////////
	// word packing and result

	always_ff @(posedge i_clk)
	begin
		if (i_stb)
		begin
			case (state)
			ST_TOKEN:
			begin
				// error token goes back to the host as is
				if (is_error)
					resp_code <= tok.raw;
			end
			ST_DATA:
			begin
				gearbox <= {gearbox[15:0], i_byte};
				if (fill == 2'd3)
				begin
					wr_data <= {gearbox, i_byte};
					wr_addr <= {i_req.buf_sel, wcnt};
				end
			end
			ST_CRC:
			begin
				// high CRC byte first
				if (!crc_second)
					crc_hi_ok <= (i_byte == crc[15:8]);
				else
					resp_code <= (crc_hi_ok && (i_byte == crc[7:0])) ? 8'h00
						: SD_RESP_CRC_ERR;
			end
			default:
			begin
			end
			endcase
		end
	end

	// CRC covers data bytes only, zeroed while waiting for the token
	assign crc_clear = !o_busy || (state == ST_TOKEN);
	assign crc_stb = i_stb && (state == ST_DATA);

	sd_crc16 u_crc (
		.i_clk   (i_clk),
		.i_clear (crc_clear),
		.i_stb   (crc_stb),
		.i_byte  (i_byte),
		.o_crc   (crc)
	);

	assign o_wr = '{en: wr_en, addr: wr_addr, data: wr_data};
	assign o_resp = '{valid: resp_valid, code: resp_code};

endmodule

`default_nettype wire

// ==== design/sd_rx_ctrl.sv ====
/*
 * host side sequencer for one block read over a four-phase req/ack handshake
 * drives chip select, receiver start and SCK enable, returns the response code
 */
`timescale 1ns/1ps
`default_nettype none

module sd_rx_ctrl
	import sdrx_pkg::*;
(
	input  wire          i_clk,
	input  wire          i_reset,
	input  wire          i_req,
	input  wire rx_req_t i_req_info,
	output logic         o_ack,
	output logic [7:0]   o_resp_code,
	output logic         o_start,
	output rx_req_t      o_req_info,
	input  wire          i_busy,
	input  wire rx_resp_t i_resp,
	output logic         o_sck_en,
	output logic         o_cs_n
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_RECV,
		S_ACK,
		S_RELEASE
	} ctrl_state_t;

	ctrl_state_t state;

	////////////////////
	// handshake FSM

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			state <= S_IDLE;
			o_ack <= 1'b0;
			o_start <= 1'b0;
			o_sck_en <= 1'b0;
			o_cs_n <= 1'b1;
		end
		else
		begin
			case (state)
			S_IDLE:
			begin
				if (i_req)
				begin
					o_cs_n <= 1'b0;
					o_start <= 1'b1;
					o_sck_en <= 1'b1;
					state <= S_RECV;
				end
			end
			S_RECV:
			begin
				// stop the clock and hand the result back
				if (i_resp.valid)
				begin
					o_start <= 1'b0;
					o_sck_en <= 1'b0;
					o_ack <= 1'b1;
					state <= S_ACK;
				end
			end
			S_ACK:
			begin
				if (!i_req)
				begin
					o_ack <= 1'b0;
					state <= S_RELEASE;
				end
			end
			default:
			begin
				// card deselected once the receiver is idle
				if (!i_busy)
				begin
					o_cs_n <= 1'b1;
					state <= S_IDLE;
				end
			end
			endcase
		end
	end

	// request and result latches
	always_ff @(posedge i_clk)
	begin
		if ((state == S_IDLE) && i_req)
			o_req_info <= i_req_info;
		if ((state == S_RECV) && i_resp.valid)
			o_resp_code <= i_resp.code;
	end

endmodule

`default_nettype wire

// ==== design/block_buffer.sv ====
/*
 * two-region word buffer for received blocks
 * receiver writes through rx_wr_t, host reads with one cycle of latency
 */
`timescale 1ns/1ps
`default_nettype none

`include "sdrx_config.svh"

module block_buffer
	import sdrx_pkg::*;
(
	input  wire                  i_clk,
	input  wire rx_wr_t          i_wr,
	input  wire [`SDRX_AW-1:0]  i_rd_addr,
	output logic [`SDRX_DW-1:0] o_rd_data
);

	// 256 words, upper half is region 1
	localparam int DEPTH = 1 << `SDRX_AW;

	logic [`SDRX_DW-1:0] mem [0:DEPTH-1];

	////////////////////
	// write port from the receiver
	always_ff @(posedge i_clk)
	begin
		if (i_wr.en)
			mem[i_wr.addr] <= i_wr.data;
	end

	// registered read for the host
	always_ff @(posedge i_clk)
	begin
		o_rd_data <= mem[i_rd_addr];
	end

endmodule

`default_nettype wire

// ==== design/sd_rx_top.sv ====
/*
 * SD card SPI block read, receive side
 * host req/ack request in, card SCK/CS/MISO, buffer read port back to the host
 */
`timescale 1ns/1ps
`default_nettype none

`include "sdrx_config.svh"

module sd_rx_top
	import sdrx_pkg::*;
(
	input  wire                  i_clk,
	input  wire                  i_reset,
	// host request
	input  wire                  i_req,
	input  wire rx_req_t         i_req_info,
	output logic                 o_ack,
	output logic [7:0]           o_resp_code,
	// card
	output logic                 o_sck,
	output logic                 o_cs_n,
	input  wire                  i_miso,
	// buffer read back
	input  wire [`SDRX_AW-1:0]  i_rd_addr,
	output logic [`SDRX_DW-1:0] o_rd_data
);

	logic     start;
	logic     busy;
	logic     sck_en;
	logic     byte_stb;
	logic [7:0] rx_byte;
	rx_req_t  req_info;
	rx_resp_t resp;
	rx_wr_t   wr;

	sd_rx_ctrl u_ctrl (
		.i_clk       (i_clk),
		.i_reset     (i_reset),
		.i_req       (i_req),
		.i_req_info  (i_req_info),
		.o_ack       (o_ack),
		.o_resp_code (o_resp_code),
		.o_start     (start),
		.o_req_info  (req_info),
		.i_busy      (busy),
		.i_resp      (resp),
		.o_sck_en    (sck_en),
		.o_cs_n      (o_cs_n)
	);

	spi_byte_rx u_spi (
		.i_clk   (i_clk),
		.i_reset (i_reset),
		.i_en    (sck_en),
		.i_miso  (i_miso),
		.o_sck   (o_sck),
		.o_stb   (byte_stb),
		.o_byte  (rx_byte)
	);

	sd_rx_data u_data (
		.i_clk   (i_clk),
		.i_reset (i_reset),
		.i_start (start),
		.i_req   (req_info),
		.o_busy  (busy),
		.i_stb   (byte_stb),
		.i_byte  (rx_byte),
		.o_wr    (wr),
		.o_resp  (resp)
	);

	block_buffer u_buf (
		.i_clk     (i_clk),
		.i_wr      (wr),
		.i_rd_addr (i_rd_addr),
		.o_rd_data (o_rd_data)
	);

endmodule

`default_nettype wire

// ==== verif/tb_clock.sv ====
/*
 * testbench clock and power-on reset
 * 4 ns clock, reset held high for the first two rising edges
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter int HALF_PERIOD = 2,
	parameter int RESET_CYCLES = 2
) (
	output logic o_clk,
	output logic o_reset
);

	initial
	begin
		o_clk = 1'b0;
		forever
			#(HALF_PERIOD) o_clk = !o_clk;
	end

	// synchronous reset, dropped right on a rising edge
	initial
	begin
		o_reset = 1'b1;
		repeat (RESET_CYCLES)
			@(posedge o_clk);
		o_reset <= 1'b0;
	end

endmodule

`default_nettype wire

// ==== verif/sd_card_model.sv ====
/*
 * SD card data-out model for the testbench
 * bytes pushed while deselected are sent MSB first, MISO moves on falling SCK
 */
`timescale 1ns/1ps
`default_nettype none

module sd_card_model (
	input  wire       i_clk,
	input  wire       i_clear,
	input  wire       i_push,
	input  wire [7:0] i_push_byte,
	input  wire       i_sck,
	input  wire       i_cs_n,
	output logic      o_miso
);

	localparam int DEPTH = 1024;

	logic [7:0] stream [0:DEPTH-1];
	int         wr_ptr = 0;
	int         rd_ptr = 0;
	int         bit_idx = 0;
	logic       active = 1'b0;
	logic [7:0] cur = 8'hFF;
	logic       miso_q = 1'b1;

	////////////////////
	// byte queue fill from the testbench
	always @(posedge i_clk)
	begin
		if (i_clear)
			wr_ptr <= 0;
		else if (i_push)
		begin
			stream[wr_ptr] <= i_push_byte;
			wr_ptr <= wr_ptr + 1;
		end
	end

	////////////////////
	// shift out
	always @(negedge i_sck or negedge i_cs_n or posedge i_cs_n)
	begin
		if (i_cs_n)
		begin
			// deselected, next select starts at the head again
			active = 1'b0;
			rd_ptr = 0;
			miso_q = 1'b1;
		end
		else
		begin
			// first bit on select, later bytes after the 8th falling edge
			if (!active || (bit_idx == 0))
			begin
				// past the end the card idles with all ones
				cur = (rd_ptr < wr_ptr) ? stream[rd_ptr] : 8'hFF;
				rd_ptr = rd_ptr + 1;
				bit_idx = 7;
				active = 1'b1;
			end
			else
				bit_idx = bit_idx - 1;
			miso_q = cur[bit_idx];
		end
	end

	assign o_miso = miso_q;

endmodule

`default_nettype wire

// ==== verif/tb_sd_rx.sv ====
/*
 * table-driven testbench for the SD card SPI receive path
 * each row goes through the card model and the req/ack handshake, then the buffer is read back
 */
`timescale 1ns/1ps
`default_nettype none

`include "sdrx_config.svh"

module tb_sd_rx
	import sdrx_pkg::*;
();

	// one transfer per row
	typedef struct packed {
		logic [3:0] lgblksz;
		logic       buf_sel;
		logic [7:0] token;
		logic [3:0] idle;
		logic [1:0] crc_bad;
		logic [7:0] code;
	} test_row_t;

	localparam int NUM_TESTS = 13;

	// lgblksz, region, token, idle bytes, bad CRC byte (1 high, 2 low), expected code
	localparam test_row_t ROWS [NUM_TESTS] = '{
		'{4'd3, 1'b0, 8'hFE, 4'd0, 2'd0, 8'h00},
		'{4'd4, 1'b1, 8'hFE, 4'd1, 2'd0, 8'h00},
		'{4'd5, 1'b0, 8'hFE, 4'd2, 2'd0, 8'h00},
		'{4'd6, 1'b1, 8'hFE, 4'd0, 2'd0, 8'h00},
		'{4'd7, 1'b0, 8'hFE, 4'd3, 2'd0, 8'h00},
		'{4'd8, 1'b1, 8'hFE, 4'd1, 2'd0, 8'h00},
		'{4'd9, 1'b0, 8'hFE, 4'd2, 2'd0, 8'h00},
		'{4'd9, 1'b1, 8'hFE, 4'd0, 2'd0, 8'h00},
		'{4'd6, 1'b0, 8'hFE, 4'd1, 2'd1, 8'h10},
		'{4'd5, 1'b1, 8'hFE, 4'd0, 2'd2, 8'h10},
		'{4'd9, 1'b0, 8'h08, 4'd2, 2'd0, 8'h08},
		'{4'd4, 1'b1, 8'h01, 4'd0, 2'd0, 8'h01},
		'{4'd3, 1'b1, 8'hFE, 4'd5, 2'd0, 8'h00}
	};

	string test_name [NUM_TESTS] = '{
		"blk8_r0", "blk16_r1", "blk32_r0", "blk64_r1", "blk128_r0", "blk256_r1",
		"blk512_r0", "blk512_r1", "crc_hi_bad", "crc_lo_bad", "err_tok_08",
		"err_tok_01", "blk8_r1_idle"
	};

	logic                clk;
	logic                reset;
	logic                req;
	rx_req_t             req_info;
	logic                ack;
	logic [7:0]          resp_code;
	logic                sck;
	logic                cs_n;
	logic                miso;
	logic [`SDRX_AW-1:0] rd_addr;
	logic [`SDRX_DW-1:0] rd_data;
	logic                card_clear;
	logic                card_push;
	logic [7:0]          card_byte;

	// bytes for the current row, and the expected buffer image
	logic [7:0]  stream_bytes [0:1023];
	int          stream_len;
	logic [31:0] shadow [0:255];
	logic        shadow_known [0:255];
	logic [31:0] lcg_state = 32'h428fde13;

	tb_clock #(
		.HALF_PERIOD  (2),
		.RESET_CYCLES (2)
	) clock_gen (
		.o_clk   (clk),
		.o_reset (reset)
	);

	sd_card_model card (
		.i_clk       (clk),
		.i_clear     (card_clear),
		.i_push      (card_push),
		.i_push_byte (card_byte),
		.i_sck       (sck),
		.i_cs_n      (cs_n),
		.o_miso      (miso)
	);

	sd_rx_top DUT (
		.i_clk       (clk),
		.i_reset     (reset),
		.i_req       (req),
		.i_req_info  (req_info),
		.o_ack       (ack),
		.o_resp_code (resp_code),
		.o_sck       (sck),
		.o_cs_n      (cs_n),
		.i_miso      (miso),
		.i_rd_addr   (rd_addr),
		.o_rd_data   (rd_data)
	);

	////////////////////
	// helpers

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
		begin
			$display("mismatch %s expected %h actual %h", name, expected, actual);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	function automatic logic [7:0] lcg_byte();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[31:24];
	endfunction

	// CCITT from zero, MSB first over the data bytes only
	function automatic logic [15:0] crc16_ccitt(input int first, input int count);
		logic [15:0] crc;
		logic        fb;
		crc = 16'h0000;
		for (int i = 0; i < count; i++)
			for (int b = 7; b >= 0; b--)
			begin
				fb = crc[15] ^ stream_bytes[first + i][b];
				crc = {crc[14:0], 1'b0};
				if (fb)
					crc = crc ^ `SDRX_CRC_POLY;
			end
		return crc;
	endfunction

	// SPI time per byte, card loading and a full read back per row
	function automatic int watchdog_cycles();
		int total;
		int bytes;
		total = 200;
		for (int t = 0; t < NUM_TESTS; t++)
		begin
			bytes = int'(ROWS[t].idle) + 1;
			if (ROWS[t].token == SD_START_TOKEN)
				bytes += (1 << ROWS[t].lgblksz) + 2;
			total += 40 * bytes + bytes + 1200;
		end
		return total;
	endfunction

	////////////////////
	// stimulus

	// idle bytes, token, data, CRC; also updates the expected buffer
	task automatic build_stream(input int t);
		int                  size;
		int                  pos;
		int                  first;
		logic [15:0]         crc;
		logic [`SDRX_AW-1:0] addr;
		size = 1 << ROWS[t].lgblksz;
		pos = 0;
		for (int i = 0; i < int'(ROWS[t].idle); i++)
		begin
			stream_bytes[pos] = 8'hFF;
			pos++;
		end
		stream_bytes[pos] = ROWS[t].token;
		pos++;
		if (ROWS[t].token == SD_START_TOKEN)
		begin
			first = pos;
			for (int i = 0; i < size; i++)
			begin
				stream_bytes[pos] = lcg_byte();
				pos++;
			end
			crc = crc16_ccitt(first, size);
			if (ROWS[t].crc_bad == 2'd1)
				crc[15:8] = crc[15:8] ^ 8'hA5;
			if (ROWS[t].crc_bad == 2'd2)
				crc[7:0] = crc[7:0] ^ 8'h5A;
			stream_bytes[pos] = crc[15:8];
			stream_bytes[pos + 1] = crc[7:0];
			pos += 2;
			// big-endian words from the region base, kept even on a CRC error
			for (int w = 0; w < size / 4; w++)
			begin
				addr = {ROWS[t].buf_sel, 7'(w)};
				shadow[addr] = {stream_bytes[first + 4 * w], stream_bytes[first + 4 * w + 1],
					stream_bytes[first + 4 * w + 2], stream_bytes[first + 4 * w + 3]};
				shadow_known[addr] = 1'b1;
			end
		end
		stream_len = pos;
	endtask

	task automatic load_card();
		@(posedge clk);
		card_clear <= 1'b1;
		@(posedge clk);
		card_clear <= 1'b0;
		for (int i = 0; i < stream_len; i++)
		begin
			@(posedge clk);
			card_push <= 1'b1;
			card_byte <= stream_bytes[i];
		end
		@(posedge clk);
		card_push <= 1'b0;
	endtask

	// four-phase request, checks the code and the ack timing
	task automatic request_block(input int t);
		int cycles;
		int min_cycles;
		// every byte costs 32 cycles of SCK
		min_cycles = 32 * stream_len - 4;
		@(negedge clk);
		check_value({test_name[t], " ack idle"}, 32'd0, 32'(ack));
		@(posedge clk);
		req_info <= '{lgblksz: ROWS[t].lgblksz, buf_sel: ROWS[t].buf_sel};
		req <= 1'b1;
		cycles = 0;
		@(negedge clk);
		while (!ack)
		begin
			@(negedge clk);
			cycles++;
		end
		check_value({test_name[t], " ack early"}, 32'd1, 32'(cycles >= min_cycles));
		check_value({test_name[t], " code"}, 32'(ROWS[t].code), 32'(resp_code));
		// ack has to wait for req to fall
		repeat (4)
		begin
			@(negedge clk);
			check_value({test_name[t], " ack hold"}, 32'd1, 32'(ack));
		end
		@(posedge clk);
		req <= 1'b0;
		@(negedge clk);
		while (ack)
			@(negedge clk);
		while (cs_n !== 1'b1)
			@(negedge clk);
	endtask

	// every word written so far, both regions
	task automatic check_buffer(input int t);
		for (int a = 0; a < 256; a++)
		begin
			if (shadow_known[a])
			begin
				@(posedge clk);
				rd_addr <= 8'(a);
				@(posedge clk);
				@(negedge clk);
				check_value($sformatf("%s word %0d", test_name[t], a), shadow[a], rd_data);
			end
		end
	endtask

	////////////////////
	// main sequence

	initial
	begin
		req = 1'b0;
		req_info = '0;
		rd_addr = '0;
		card_clear = 1'b0;
		card_push = 1'b0;
		card_byte = 8'h00;
		for (int a = 0; a < 256; a++)
			shadow_known[a] = 1'b0;
		@(negedge clk);
		while (reset)
			@(negedge clk);
		check_value("reset ack", 32'd0, 32'(ack));
		check_value("reset cs_n", 32'd1, 32'(cs_n));
		check_value("reset sck", 32'd0, 32'(sck));
		for (int t = 0; t < NUM_TESTS; t++)
		begin
			build_stream(t);
			load_card();
			request_block(t);
			check_buffer(t);
		end
		$display("Simulation passed");
		$finish;
	end

	initial
	begin : watchdog
		int limit;
		limit = watchdog_cycles();
		repeat (limit)
			@(posedge clk);
		$display("timeout: the tests did not finish within %0d cycles", limit);
		$display("Simulation failed");
		$fatal(1);
	end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+common
common/sdrx_pkg.sv
design/spi_byte_rx.sv
sd_rx/sd_crc16.sv
sd_rx/sd_rx_data.sv
design/sd_rx_ctrl.sv
design/block_buffer.sv
design/sd_rx_top.sv
verif/tb_clock.sv
verif/sd_card_model.sv
verif/tb_sd_rx.sv

// ==== Makefile ====
# Verilator build and run for the SD receive path testbench

TOP := tb_sd_rx

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal -f project.f --top-module $(TOP) -o V$(TOP)

run: compile
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@grep -q "^Simulation passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
